// File: build.f
rtl/rv_fetch_pkg.sv
rtl/rv_pc_gen.sv
rtl/rv_imem_bram.sv
rtl/rv_if_bram.sv
rtl/rv_jal_redirect.sv
rtl/rv_fetch_top.sv
verif/tb_rv_fetch.sv

// File: verif/tb_rv_fetch.sv
`timescale 1ns/1ns

module tb_rv_fetch;

  // Table geometry
  localparam int NUM_TESTS    = 7;
  localparam int PROG_LEN     = 16;
  localparam int RESET_CYCLES = 4;

  // Ready modes
  localparam int READY_ALWAYS  = 0;
  localparam int READY_PATTERN = 1;
  localparam int READY_RANDOM  = 2;

  // DUT ports
  logic                             clk;
  logic                             rst_n;
  logic                             out_ready;
  logic                             out_valid;
  logic [rv_fetch_pkg::ILEN-1:0]    out_instr;
  logic [rv_fetch_pkg::XLEN-1:0]    out_pc;
  logic [rv_fetch_pkg::XLEN-1:0]    out_pc_plus4;
  logic                             imem_we;
  logic [rv_fetch_pkg::IMEM_AW-1:0] imem_waddr;
  logic [rv_fetch_pkg::ILEN-1:0]    imem_wdata;

  // Stimulus table
  string       test_name    [NUM_TESTS];
  logic [31:0] test_prog    [NUM_TESTS][PROG_LEN];
  int          test_mode    [NUM_TESTS];
  logic [7:0]  test_pattern [NUM_TESTS];
  int          test_count   [NUM_TESTS];

  // Expected stream of the current test
  logic [31:0] exp_instr [$];
  logic [31:0] exp_pc    [$];

  // Run state
  string       cur_name;
  int          test_errors;
  int          pass_count;
  int          fail_count;
  logic [31:0] rng_state;
  int          limit_cycles = 0;

  rv_fetch_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_ready    (out_ready),
    .out_valid    (out_valid),
    .out_instr    (out_instr),
    .out_pc       (out_pc),
    .out_pc_plus4 (out_pc_plus4),
    .imem_we      (imem_we),
    .imem_waddr   (imem_waddr),
    .imem_wdata   (imem_wdata)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ADDI rd,x0,imm
  function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b000, rd, 7'h13};
  endfunction

  // JAL rd,offset in the scrambled J-type layout
  function automatic logic [31:0] jal_word(input logic [4:0] rd, input int offset);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_fetch_pkg::OP_JAL};
  endfunction

  function automatic bit is_jal(input logic [31:0] word);
    return word[6:0] == rv_fetch_pkg::OP_JAL;
  endfunction

  // Offset back out of a JAL, bit by bit from the ISA layout
  function automatic logic [31:0] jal_offset(input logic [31:0] word);
    logic [20:0] imm;
    imm[0]     = 1'b0;
    imm[10:1]  = word[30:21];
    imm[11]    = word[20];
    imm[19:12] = word[19:12];
    imm[20]    = word[31];
    return {{11{imm[20]}}, imm};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Ready level for one cycle of a test
  function automatic logic next_ready(input int t, input int cyc);
    if (test_mode[t] == READY_PATTERN) begin
      return test_pattern[t][cyc % 8];
    end else if (test_mode[t] == READY_RANDOM) begin
      rng_state = xorshift(rng_state);
      return rng_state[4];
    end
    return 1'b1;
  endfunction

  task automatic set_test(input int t, input string name, input int mode,
                          input logic [7:0] pattern, input int count);
    test_name[t]    = name;
    test_mode[t]    = mode;
    test_pattern[t] = pattern;
    test_count[t]   = count;
  endtask

  task automatic build_table();
    // Filler ALU words, immediate tied to the word address
    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int i = 0; i < PROG_LEN; i++) begin
        test_prog[t][i] = alu_word(5'(i % 31 + 1), {4'ha, 8'(i)});
      end
    end
    set_test(0, "reset_first_word", READY_ALWAYS, 8'hff, 4);
    set_test(1, "straight_line", READY_ALWAYS, 8'hff, 12);
    // Word 2 jumps to word 6
    set_test(2, "forward_jal", READY_ALWAYS, 8'hff, 10);
    test_prog[2][2] = jal_word(5'd1, 16);
    // Word 3 jumps back to word 1
    set_test(3, "backward_jal_loop", READY_ALWAYS, 8'hff, 14);
    test_prog[3][3] = jal_word(5'd0, -8);
    // Alternating ready puts a stall right after every redirect edge
    set_test(4, "stall_after_jal", READY_PATTERN, 8'b1010_1010, 14);
    test_prog[4][1] = jal_word(5'd1, 12);
    test_prog[4][6] = jal_word(5'd0, -8);
    set_test(5, "stall_pattern_mixed", READY_PATTERN, 8'b1101_1001, 14);
    test_prog[5][1] = jal_word(5'd1, 12);
    test_prog[5][6] = jal_word(5'd0, -8);
    // Loop 1,2,5,6,8,9 with three jumps
    set_test(6, "random_ready", READY_RANDOM, 8'h00, 24);
    test_prog[6][2] = jal_word(5'd1, 12);
    test_prog[6][6] = jal_word(5'd1, 8);
    test_prog[6][9] = jal_word(5'd0, -32);
  endtask

  // Reference walk from the reset PC
  // Each word shows up once, and the words behind a JAL never show up
  task automatic build_expected(input int t);
    logic [31:0] pc;
    logic [31:0] word;
    exp_instr.delete();
    exp_pc.delete();
    pc = rv_fetch_pkg::RESET_PC;
    while (exp_instr.size() < test_count[t]) begin
      word = test_prog[t][int'(pc[5:2])];
      exp_instr.push_back(word);
      exp_pc.push_back(pc);
      pc = is_jal(word) ? pc + jal_offset(word) : pc + 32'd4;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s expected %h actual %h", cur_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Reset runs with ready high, which parks word 0 in the BRAM output
  // Rest of the image goes in while the DUT sits stalled
  task automatic load_and_reset(input int t);
    @(posedge clk);
    rst_n      <= 1'b0;
    out_ready  <= 1'b1;
    imem_we    <= 1'b1;
    imem_waddr <= '0;
    imem_wdata <= test_prog[t][0];
    for (int i = 1; i < PROG_LEN; i++) begin
      @(posedge clk);
      if (i == RESET_CYCLES) begin
        rst_n     <= 1'b1;
        out_ready <= 1'b0;
      end
      imem_waddr <= (rv_fetch_pkg::IMEM_AW)'(i);
      imem_wdata <= test_prog[t][i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic run_test(input int t);
    int          cyc;
    int          handshakes;
    int          ready_edges;
    logic        prev_ready;
    logic        prev_valid;
    logic [31:0] prev_instr;
    logic [31:0] prev_pc;
    logic [31:0] prev_pc4;
    cur_name    = test_name[t];
    test_errors = 0;
    build_expected(t);
    load_and_reset(t);
    cyc         = 0;
    handshakes  = 0;
    ready_edges = 0;
    out_ready <= next_ready(t, 0);
    while (handshakes < test_count[t]) begin
      @(posedge clk);
      // Values seen here are the ones the DUT sampled at this edge
      if (ready_edges < 2) begin
        // Two ready edges of fetch latency before the slot fills
        check_value("idle out_valid", 32'd0, out_valid);
        check_value("idle out_instr", rv_fetch_pkg::I_NOP, out_instr);
      end else if (!prev_ready) begin
        // Stall edge, nothing on the output may move
        check_value("hold out_valid", prev_valid, out_valid);
        check_value("hold out_instr", prev_instr, out_instr);
        check_value("hold out_pc", prev_pc, out_pc);
        check_value("hold out_pc_plus4", prev_pc4, out_pc_plus4);
      end
      if (out_valid && out_ready) begin
        check_value("out_instr", exp_instr[handshakes], out_instr);
        check_value("out_pc", exp_pc[handshakes], out_pc);
        check_value("out_pc_plus4", exp_pc[handshakes] + 32'd4, out_pc_plus4);
        handshakes++;
      end
      if (out_ready) begin
        ready_edges++;
      end
      prev_ready = out_ready;
      prev_valid = out_valid;
      prev_instr = out_instr;
      prev_pc    = out_pc;
      prev_pc4   = out_pc_plus4;
      cyc++;
      out_ready <= next_ready(t, cyc);
    end
    // Park the pipeline before the next reset
    out_ready <= 1'b0;
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS  %s  (%0d transfers, %0d cycles)", cur_name, handshakes, cyc);
    end else begin
      fail_count++;
      $display("FAIL  %s  (%0d mismatches)", cur_name, test_errors);
    end
  endtask

  // Watchdog, sized from the transfer counts
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", limit_cycles);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    int total;
    rst_n      = 1'b0;
    out_ready  = 1'b0;
    imem_we    = 1'b0;
    imem_waddr = '0;
    imem_wdata = '0;
    rng_state  = 32'd51024;
    pass_count = 0;
    fail_count = 0;
    build_table();
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += test_count[t];
    end
    // Eight cycles per transfer plus load and reset per test
    limit_cycles = total * 8 + NUM_TESTS * (PROG_LEN + 8) + 50;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: rtl/rv_fetch_top.sv
`timescale 1ns/1ns

module rv_fetch_top (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             out_ready,
  output logic                             out_valid,
  output logic [rv_fetch_pkg::ILEN-1:0]    out_instr,
  output logic [rv_fetch_pkg::XLEN-1:0]    out_pc,
  output logic [rv_fetch_pkg::XLEN-1:0]    out_pc_plus4,
  input  logic                             imem_we,
  input  logic [rv_fetch_pkg::IMEM_AW-1:0] imem_waddr,
  input  logic [rv_fetch_pkg::ILEN-1:0]    imem_wdata
);

  // Fetch address and its successor
  logic [rv_fetch_pkg::XLEN-1:0] pc;
  logic [rv_fetch_pkg::XLEN-1:0] pc_plus4;

  // Registered BRAM read data
  logic [rv_fetch_pkg::ILEN-1:0] instr_bram;

  // Early-branch steering
  logic                          redirect;
  logic [rv_fetch_pkg::XLEN-1:0] redirect_pc;

  // PC generator, held by downstream back-pressure
  rv_pc_gen pc_gen_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ready       (out_ready),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (pc),
    .pc_plus4    (pc_plus4)
  );

  // Instruction BRAM; read enable doubles as stall
  rv_imem_bram imem_i (
    .clk   (clk),
    .we    (imem_we),
    .waddr (imem_waddr),
    .wdata (imem_wdata),
    .re    (out_ready),
    .raddr (pc),
    .rdata (instr_bram)
  );

  // Fetch adapter, the IF/ID slot drives the outputs directly
  rv_if_bram if_bram_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .if_id_flush (redirect),
    .ready       (out_ready),
    .pc          (pc),
    .pc_plus4    (pc_plus4),
    .instr_bram  (instr_bram),
    .pc_id       (out_pc),
    .pc_plus4_id (out_pc_plus4),
    .instr_id    (out_instr),
    .instr_valid (out_valid)
  );

  // JAL detect on the IF/ID slot
  rv_jal_redirect jal_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_id    (out_instr),
    .instr_valid (out_valid),
    .ready       (out_ready),
    .pc_id       (out_pc),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

endmodule

// File: rtl/rv_jal_redirect.sv
`timescale 1ns/1ns

module rv_jal_redirect (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv_fetch_pkg::ILEN-1:0] instr_id,
  input  logic                          instr_valid,
  input  logic                          ready,
  input  logic [rv_fetch_pkg::XLEN-1:0] pc_id,
  output logic                          redirect,
  output logic [rv_fetch_pkg::XLEN-1:0] redirect_pc
);

  // Opcode match for JAL
  logic                          is_jal;
  // Sign-extended J-type offset
  logic [rv_fetch_pkg::XLEN-1:0] imm_j;

  assign is_jal = (instr_id[6:0] == rv_fetch_pkg::OP_JAL);

  // J-type immediate layout in the word:
  //   [31]    -> imm[20]
  //   [30:21] -> imm[10:1]
  //   [20]    -> imm[11]
  //   [19:12] -> imm[19:12]
  // Bit 0 of the offset is always zero
  assign imm_j = {
    {(rv_fetch_pkg::XLEN-21){instr_id[31]}},
    instr_id[31],
    instr_id[19:12],
    instr_id[20],
    instr_id[30:21],
    1'b0
  };

  // Target is relative to the JAL's own address
  assign redirect_pc = pc_id + imm_j;

  // Only a live JAL on an advancing cycle steers fetch
  // A stalled slot waits, so the PC and flush see one clean edge
  assign redirect = instr_valid && ready && is_jal;

  // No compressed support, so a target must be word aligned
  a_target_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect |-> (redirect_pc[1:0] == 2'b00)
  ) else $error("JAL target misaligned: %h", redirect_pc);

endmodule

// File: rtl/rv_if_bram.sv
`timescale 1ns/1ns

module rv_if_bram (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          if_id_flush,
  input  logic                          ready,
  input  logic [rv_fetch_pkg::XLEN-1:0] pc,
  input  logic [rv_fetch_pkg::XLEN-1:0] pc_plus4,
  input  logic [rv_fetch_pkg::ILEN-1:0] instr_bram,
  output logic [rv_fetch_pkg::XLEN-1:0] pc_id,
  output logic [rv_fetch_pkg::XLEN-1:0] pc_plus4_id,
  output logic [rv_fetch_pkg::ILEN-1:0] instr_id,
  output logic                          instr_valid
);

  // PC stage that sits alongside the BRAM output register
  logic [rv_fetch_pkg::XLEN-1:0] pc_buf;
  logic [rv_fetch_pkg::XLEN-1:0] pc_plus4_buf;

  // Set for one ready edge after a flush to squash the stale BRAM word
  logic flush_extend;

  // BRAM output holds a fetch of the live PC stream
  logic bram_valid;

  // PC path, two ready-qualified stages
  // First stage matches the BRAM read, second is the IF/ID slot
  // Keeps tracking through flushes; only the instruction is squashed
  always_ff @(posedge clk) begin
    if (ready) begin
      pc_buf       <= pc;
      pc_plus4_buf <= pc_plus4;
      pc_id        <= pc_buf;
      pc_plus4_id  <= pc_plus4_buf;
    end
  end

  // Fetch stage valid
  // Whatever the BRAM output held through reset is not a fetch of RESET_PC,
  // so the first ready edge out of reset only starts the read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bram_valid <= 1'b0;
    end else if (ready) begin
      bram_valid <= 1'b1;
    end
  end

  // Flush extension
  // The BRAM has already started reading the fall-through word when the
  // redirect lands, so that word must be dropped too
  // Under stall the stale word is held, so the flag waits for a ready edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flush_extend <= 1'b0;
    end else if (if_id_flush) begin
      flush_extend <= 1'b1;
    end else if (ready) begin
      flush_extend <= 1'b0;
    end
  end

  // IF/ID instruction slot
  // Bubbles carry the NOP encoding with valid low
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush || flush_extend || !bram_valid) begin
      instr_id    <= rv_fetch_pkg::I_NOP;
      instr_valid <= 1'b0;
    end else if (ready) begin
      instr_id    <= instr_bram;
      instr_valid <= 1'b1;
    end
  end

  // A flushed slot is empty on the next cycle
  a_flush_bubble: assert property (
    @(posedge clk) disable iff (!rst_n)
    if_id_flush |=> !instr_valid
  ) else $error("valid instruction right after flush");

  // Empty slot always holds the bubble encoding
  a_bubble_nop: assert property (
    @(posedge clk) disable iff (!rst_n)
    !instr_valid |-> (instr_id == rv_fetch_pkg::I_NOP)
  ) else $error("invalid slot not NOP: %h", instr_id);

endmodule

// File: rtl/rv_imem_bram.sv
`timescale 1ns/1ns

module rv_imem_bram (
  input  logic                             clk,
  input  logic                             we,
  input  logic [rv_fetch_pkg::IMEM_AW-1:0] waddr,
  input  logic [rv_fetch_pkg::ILEN-1:0]    wdata,
  input  logic                             re,
  input  logic [rv_fetch_pkg::XLEN-1:0]    raddr,
  output logic [rv_fetch_pkg::ILEN-1:0]    rdata
);

  // Word storage, inferred as block RAM
  logic [rv_fetch_pkg::ILEN-1:0] mem [rv_fetch_pkg::IMEM_DEPTH];

  // Word index taken above the byte offset
  logic [rv_fetch_pkg::IMEM_AW-1:0] raddr_word;

  assign raddr_word = raddr[rv_fetch_pkg::IMEM_AW+1:2];

  // Write port, loaded by the program image
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read port
  // Output holds while re is low, so a stalled fetch keeps its word
  // This is the one cycle of latency the fetch adapter makes up for
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr_word];
    end
  end

endmodule

// File: rtl/rv_pc_gen.sv
`timescale 1ns/1ns

module rv_pc_gen (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          ready,
  input  logic                          redirect,
  input  logic [rv_fetch_pkg::XLEN-1:0] redirect_pc,
  output logic [rv_fetch_pkg::XLEN-1:0] pc,
  output logic [rv_fetch_pkg::XLEN-1:0] pc_plus4
);

  // Next sequential address
  // Also handed down the pipe as the link value for JAL
  assign pc_plus4 = pc + rv_fetch_pkg::XLEN'(4);

  // Program counter
  // Only advances on a ready edge, so a stall freezes the fetch address
  // and the BRAM keeps presenting the same word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= rv_fetch_pkg::RESET_PC;
    end else if (ready) begin
      // Redirect wins over the sequential step
      if (redirect) begin
        pc <= redirect_pc;
      end else begin
        pc <= pc_plus4;
      end
    end
  end

  // Fetch address must stay on a word boundary
  // Covers both the sequential step and redirect targets
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// File: rtl/rv_fetch_pkg.sv
package rv_fetch_pkg;

  // Architectural widths
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Instruction memory geometry, in 32-bit words
  localparam int IMEM_DEPTH = 256;
  localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

  // First address fetched out of reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // ADDI x0,x0,0 used as the bubble encoding
  localparam logic [ILEN-1:0] I_NOP = 32'h0000_0013;

  // Major opcode of JAL
  localparam logic [6:0] OP_JAL = 7'b110_1111;

endpackage
